/* mpmem_defines.svh */
`ifndef MPMEM_DEFINES_SVH
`define MPMEM_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MPMEM_WIDTH      32  // Data bits per word.
`define MPMEM_NUMADDR    256
`define MPMEM_BITADDR    8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank interleave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MPMEM_NUMVBNK    4   // Bank is address mod this.
`define MPMEM_BITVBNK    2
`define MPMEM_NUMVROW    64  // Rows per bank.
`define MPMEM_BITVROW    6

// Bank read command to data out.
`define MPMEM_SRAM_DELAY 2

`endif

/* mpmem_data_pkg.sv */
`include "mpmem_defines.svh"

package mpmem_data_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types seen on the external ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [`MPMEM_BITADDR-1:0] addr_t;  // Word address.
  typedef logic [`MPMEM_WIDTH-1:0]   data_t;  // Data word.

endpackage

/* mpmem_ctrl_pkg.sv */
`include "mpmem_defines.svh"

package mpmem_ctrl_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Internal layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [`MPMEM_BITVBNK-1:0] vbnk_t;  // Bank index.
  typedef logic [`MPMEM_BITVROW-1:0] vrow_t;  // Row within a bank.

  // Physical location, bank above row.
  typedef logic [`MPMEM_BITVBNK+`MPMEM_BITVROW-1:0] padr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Controller state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    INIT_CLEAR,  // Sweeping rows to zero.
    INIT_DONE
  } init_state_e;

endpackage

/* mpmem_ctrl.sv */
`timescale 1ns/1ns
`include "mpmem_defines.svh"

module mpmem_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  // Read/write port.
  input  logic                          rw_read,
  input  logic                          rw_write,
  input  mpmem_data_pkg::addr_t         rw_addr,
  input  mpmem_data_pkg::data_t         rw_din,
  // Read-only port.
  input  logic                          read,
  input  mpmem_data_pkg::addr_t         rd_addr,
  output logic                          ready,
  // One-port copies, write lines shared with the t2 copies.
  output logic [`MPMEM_NUMVBNK-1:0]     t1_read,
  output logic [`MPMEM_NUMVBNK-1:0]     t1_write,
  output mpmem_ctrl_pkg::vrow_t         t1_row,
  output mpmem_data_pkg::data_t         t1_din,
  // Read side of the one-read-one-write copies.
  output logic [`MPMEM_NUMVBNK-1:0]     t2_read,
  output mpmem_ctrl_pkg::vrow_t         t2_rd_row,
  // Return path tags.
  output logic                          rw_issue,
  output mpmem_ctrl_pkg::vbnk_t         rw_bank,
  output mpmem_ctrl_pkg::vrow_t         rw_row,
  output logic                          rd_issue,
  output mpmem_ctrl_pkg::vbnk_t         rd_bank,
  output mpmem_ctrl_pkg::vrow_t         rd_row
);

  mpmem_ctrl_pkg::init_state_e    state;
  mpmem_ctrl_pkg::vrow_t          init_row;

  mpmem_ctrl_pkg::vbnk_t          rw_vbnk;
  mpmem_ctrl_pkg::vrow_t          rw_vrow;
  mpmem_ctrl_pkg::vbnk_t          rd_vbnk;
  mpmem_ctrl_pkg::vrow_t          rd_vrow;

  logic                           rw_wr_acc;
  logic                           rw_rd_acc;
  logic                           rd_acc;
  logic [`MPMEM_NUMVBNK-1:0]      rw_sel;
  logic [`MPMEM_NUMVBNK-1:0]      rd_sel;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Init sweep
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mpmem_ctrl_pkg::INIT_CLEAR;
      init_row <= '0;
    end else if (state == mpmem_ctrl_pkg::INIT_CLEAR) begin
      init_row <= init_row + 1'b1;
      if (init_row == mpmem_ctrl_pkg::vrow_t'(`MPMEM_NUMVROW-1)) begin
        state <= mpmem_ctrl_pkg::INIT_DONE;  // Last row goes out this cycle.
      end
    end
  end

  assign ready = (state == mpmem_ctrl_pkg::INIT_DONE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rw_vbnk = mpmem_ctrl_pkg::vbnk_t'(rw_addr % `MPMEM_NUMVBNK);
  assign rw_vrow = mpmem_ctrl_pkg::vrow_t'(rw_addr / `MPMEM_NUMVBNK);
  assign rd_vbnk = mpmem_ctrl_pkg::vbnk_t'(rd_addr % `MPMEM_NUMVBNK);
  assign rd_vrow = mpmem_ctrl_pkg::vrow_t'(rd_addr / `MPMEM_NUMVBNK);

  assign rw_sel = {{(`MPMEM_NUMVBNK-1){1'b0}}, 1'b1} << rw_vbnk;
  assign rd_sel = {{(`MPMEM_NUMVBNK-1){1'b0}}, 1'b1} << rd_vbnk;

  // Write wins over a read on the same port.
  assign rw_wr_acc = ready && rw_write;
  assign rw_rd_acc = ready && rw_read && !rw_write;
  assign rd_acc    = ready && read;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bank commands
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      t1_read  <= '0;
      t1_write <= '0;
      t2_read  <= '0;
      rw_issue <= 1'b0;
      rd_issue <= 1'b0;
    end else begin
      t1_read  <= rw_rd_acc ? rw_sel : '0;
      t1_write <= !ready ? '1 : (rw_wr_acc ? rw_sel : '0);  // Sweep hits all banks.
      t2_read  <= rd_acc ? rd_sel : '0;
      rw_issue <= rw_rd_acc;
      rd_issue <= rd_acc;
    end
  end

  always_ff @(posedge clk) begin
    t1_row    <= ready ? rw_vrow : init_row;
    t1_din    <= ready ? rw_din : '0;
    t2_rd_row <= rd_vrow;
    rw_bank   <= rw_vbnk;
    rw_row    <= rw_vrow;
    rd_bank   <= rd_vbnk;
    rd_row    <= rd_vrow;
  end

endmodule

/* mpmem_bank_1rw.sv */
`timescale 1ns/1ns
`include "mpmem_defines.svh"

module mpmem_bank_1rw (
  input  logic                   clk,
  input  logic                   read,
  input  logic                   write,
  input  mpmem_ctrl_pkg::vrow_t  row,
  input  mpmem_data_pkg::data_t  din,
  output mpmem_data_pkg::data_t  dout
);

  mpmem_data_pkg::data_t mem [`MPMEM_NUMVROW];
  mpmem_data_pkg::data_t rd_pipe [`MPMEM_SRAM_DELAY];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage, one access per cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (write) begin
      mem[row] <= din;
    end
  end

  // Read before write, a read alongside a write gets the old word.
  always_ff @(posedge clk) begin
    if (read) begin
      rd_pipe[0] <= mem[row];  // Old word on the sampled row.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    for (int i = 1; i < `MPMEM_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[`MPMEM_SRAM_DELAY-1];

endmodule

/* mpmem_bank_1r1w.sv */
`timescale 1ns/1ns
`include "mpmem_defines.svh"

module mpmem_bank_1r1w (
  input  logic                   clk,
  // Write port, same write as the one-port copy.
  input  logic                   write,
  input  mpmem_ctrl_pkg::vrow_t  wr_row,
  input  mpmem_data_pkg::data_t  din,
  // Independent read port.
  input  logic                   read,
  input  mpmem_ctrl_pkg::vrow_t  rd_row,
  output mpmem_data_pkg::data_t  dout
);

  mpmem_data_pkg::data_t mem [`MPMEM_NUMVROW];
  mpmem_data_pkg::data_t rd_pipe [`MPMEM_SRAM_DELAY];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_row] <= din;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Sampled before the same-edge write lands, so a collision sees old data.
  always_ff @(posedge clk) begin
    if (read) begin
      rd_pipe[0] <= mem[rd_row];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 1; i < `MPMEM_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[`MPMEM_SRAM_DELAY-1];  // Last stage.

endmodule

/* mpmem_rd_mux.sv */
`timescale 1ns/1ns
`include "mpmem_defines.svh"

module mpmem_rd_mux (
  input  logic                   clk,
  input  logic                   rst,
  // Tag of a read issued to the banks.
  input  logic                   issue,
  input  mpmem_ctrl_pkg::vbnk_t  bank,
  input  mpmem_ctrl_pkg::vrow_t  row,
  // Read data from every bank copy on this port.
  input  mpmem_data_pkg::data_t  bank_dout [`MPMEM_NUMVBNK],
  output logic                   vld,
  output mpmem_data_pkg::data_t  dout,
  output mpmem_ctrl_pkg::padr_t  padr
);

  logic [`MPMEM_SRAM_DELAY-1:0]  iss_line;
  mpmem_ctrl_pkg::vbnk_t         bnk_line [`MPMEM_SRAM_DELAY];
  mpmem_ctrl_pkg::vrow_t         row_line [`MPMEM_SRAM_DELAY];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Delay line, matched to the bank read latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      iss_line <= '0;
    end else begin
      iss_line[0] <= issue;
      for (int i = 1; i < `MPMEM_SRAM_DELAY; i++) begin
        iss_line[i] <= iss_line[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bnk_line[0] <= bank;
    row_line[0] <= row;
    for (int i = 1; i < `MPMEM_SRAM_DELAY; i++) begin
      bnk_line[i] <= bnk_line[i-1];
      row_line[i] <= row_line[i-1];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign vld  = iss_line[`MPMEM_SRAM_DELAY-1];
  assign dout = bank_dout[bnk_line[`MPMEM_SRAM_DELAY-1]];  // Bank data lands now.
  assign padr = {bnk_line[`MPMEM_SRAM_DELAY-1], row_line[`MPMEM_SRAM_DELAY-1]};

endmodule

/* mpmem_top.sv */
`timescale 1ns/1ns
`include "mpmem_defines.svh"

module mpmem_top (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   ready,
  // Read/write port.
  input  logic                   rw_read,
  input  logic                   rw_write,
  input  mpmem_data_pkg::addr_t  rw_addr,
  input  mpmem_data_pkg::data_t  rw_din,
  output logic                   rw_vld,
  output mpmem_data_pkg::data_t  rw_dout,
  output mpmem_ctrl_pkg::padr_t  rw_padr,
  // Read-only port.
  input  logic                   read,
  input  mpmem_data_pkg::addr_t  rd_addr,
  output logic                   rd_vld,
  output mpmem_data_pkg::data_t  rd_dout,
  output mpmem_ctrl_pkg::padr_t  rd_padr
);

  logic [`MPMEM_NUMVBNK-1:0]  t1_read;
  logic [`MPMEM_NUMVBNK-1:0]  t1_write;
  mpmem_ctrl_pkg::vrow_t      t1_row;
  mpmem_data_pkg::data_t      t1_din;
  logic [`MPMEM_NUMVBNK-1:0]  t2_read;
  mpmem_ctrl_pkg::vrow_t      t2_rd_row;

  logic                       rw_issue;
  mpmem_ctrl_pkg::vbnk_t      rw_bank;
  mpmem_ctrl_pkg::vrow_t      rw_row;
  logic                       rd_issue;
  mpmem_ctrl_pkg::vbnk_t      rd_bank;
  mpmem_ctrl_pkg::vrow_t      rd_row;

  mpmem_data_pkg::data_t      t1_dout [`MPMEM_NUMVBNK];
  mpmem_data_pkg::data_t      t2_dout [`MPMEM_NUMVBNK];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Controller
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  mpmem_ctrl ctrl (
    .clk       (clk),
    .rst       (rst),
    .rw_read   (rw_read),
    .rw_write  (rw_write),
    .rw_addr   (rw_addr),
    .rw_din    (rw_din),
    .read      (read),
    .rd_addr   (rd_addr),
    .ready     (ready),
    .t1_read   (t1_read),
    .t1_write  (t1_write),
    .t1_row    (t1_row),
    .t1_din    (t1_din),
    .t2_read   (t2_read),
    .t2_rd_row (t2_rd_row),
    .rw_issue  (rw_issue),
    .rw_bank   (rw_bank),
    .rw_row    (rw_row),
    .rd_issue  (rd_issue),
    .rd_bank   (rd_bank),
    .rd_row    (rd_row)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bank copies, every write goes to both
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar b = 0; b < `MPMEM_NUMVBNK; b++) begin : g_bank
    mpmem_bank_1rw bank_1rw (
      .clk   (clk),
      .read  (t1_read[b]),
      .write (t1_write[b]),
      .row   (t1_row),
      .din   (t1_din),
      .dout  (t1_dout[b])
    );

    mpmem_bank_1r1w bank_1r1w (
      .clk    (clk),
      .write  (t1_write[b]),
      .wr_row (t1_row),
      .din    (t1_din),
      .read   (t2_read[b]),
      .rd_row (t2_rd_row),
      .dout   (t2_dout[b])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Return paths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  mpmem_rd_mux rw_ret (
    .clk       (clk),
    .rst       (rst),
    .issue     (rw_issue),
    .bank      (rw_bank),
    .row       (rw_row),
    .bank_dout (t1_dout),
    .vld       (rw_vld),
    .dout      (rw_dout),
    .padr      (rw_padr)
  );

  mpmem_rd_mux rd_ret (
    .clk       (clk),
    .rst       (rst),
    .issue     (rd_issue),
    .bank      (rd_bank),
    .row       (rd_row),
    .bank_dout (t2_dout),
    .vld       (rd_vld),
    .dout      (rd_dout),
    .padr      (rd_padr)
  );

endmodule

/* mpmem_tb.sv */
`timescale 1ns/1ns
`include "mpmem_defines.svh"

module mpmem_tb;

  localparam int LATENCY     = `MPMEM_SRAM_DELAY + 1;  // Request drive to visible vld.
  localparam int N_STREAM    = 200;
  localparam int N_COLLIDE   = 16;
  localparam int N_BOTH      = 16;
  localparam int NUM_OPS     = 3 * `MPMEM_NUMADDR + N_STREAM + 2 * N_COLLIDE + 2 * N_BOTH;
  localparam int WATCHDOG_NS = (NUM_OPS + `MPMEM_NUMVROW + 100) * 4;

  typedef struct packed {
    mpmem_data_pkg::data_t data;
    mpmem_ctrl_pkg::padr_t padr;
    logic [31:0]           due;   // Cycle count when vld must be seen.
  } exp_t;

  logic                  clk;
  logic                  rst;
  logic                  ready;
  logic                  rw_read;
  logic                  rw_write;
  mpmem_data_pkg::addr_t rw_addr;
  mpmem_data_pkg::data_t rw_din;
  logic                  rw_vld;
  mpmem_data_pkg::data_t rw_dout;
  mpmem_ctrl_pkg::padr_t rw_padr;
  logic                  read;
  mpmem_data_pkg::addr_t rd_addr;
  logic                  rd_vld;
  mpmem_data_pkg::data_t rd_dout;
  mpmem_ctrl_pkg::padr_t rd_padr;

  mpmem_data_pkg::data_t model [`MPMEM_NUMADDR];
  exp_t                  rw_q [$];
  exp_t                  rd_q [$];
  int                    cycle = 0;
  logic                  ready_seen = 1'b0;
  logic [31:0]           lfsr = 32'h5876_f03f;

  mpmem_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .rw_read  (rw_read),
    .rw_write (rw_write),
    .rw_addr  (rw_addr),
    .rw_din   (rw_din),
    .rw_vld   (rw_vld),
    .rw_dout  (rw_dout),
    .rw_padr  (rw_padr),
    .read     (read),
    .rd_addr  (rd_addr),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rd_padr  (rd_padr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("Timeout: the tests did not finish in time");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Bank is address mod bank count, row is address over bank count.
  function automatic mpmem_ctrl_pkg::padr_t expect_padr(input mpmem_data_pkg::addr_t a);
    mpmem_ctrl_pkg::vbnk_t b;
    mpmem_ctrl_pkg::vrow_t r;
    b = mpmem_ctrl_pkg::vbnk_t'(a % `MPMEM_NUMVBNK);
    r = mpmem_ctrl_pkg::vrow_t'(a / `MPMEM_NUMVBNK);
    return {b, r};
  endfunction

  task automatic check_data(input mpmem_data_pkg::data_t got, input mpmem_data_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR: %0t ns: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_padr(input mpmem_ctrl_pkg::padr_t got, input mpmem_ctrl_pkg::padr_t exp,
                            input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR: %0t ns: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Port 0 is the read/write port, port 1 the read-only port.
  task automatic check_return(input bit port, input logic vld, input mpmem_data_pkg::data_t dout,
                              input mpmem_ctrl_pkg::padr_t padr);
    exp_t  e;
    string name;
    int    depth;
    name  = port ? "rd" : "rw";
    depth = port ? rd_q.size() : rw_q.size();
    if (vld === 1'b1) begin
      if (depth == 0) begin
        stop_with_failure($sformatf("%s_vld came at %0t ns with no read outstanding", name, $time));
      end else begin
        e = port ? rd_q.pop_front() : rw_q.pop_front();
        if (e.due != cycle) begin
          stop_with_failure($sformatf("%s_vld came in cycle %0d, it was due in cycle %0d",
                                      name, cycle, e.due));
        end else begin
          check_data(dout, e.data, {name, "_dout"});
          check_padr(padr, e.padr, {name, "_padr"});
        end
      end
    end else if (depth != 0) begin
      e = port ? rd_q[0] : rw_q[0];
      if (e.due <= cycle) begin
        stop_with_failure($sformatf("%s_vld missing in cycle %0d", name, cycle));
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      if (ready_seen && ready !== 1'b1) begin
        stop_with_failure("ready dropped after it had risen");
      end
      check_return(1'b0, rw_vld, rw_dout, rw_padr);
      check_return(1'b1, rd_vld, rd_dout, rd_padr);
    end
  end

  // One request cycle on both ports; reads take the model before the write lands.
  task automatic drive_cycle(input logic rw_rd, input logic rw_wr, input mpmem_data_pkg::addr_t rw_a,
                             input mpmem_data_pkg::data_t rw_d, input logic rd_rd,
                             input mpmem_data_pkg::addr_t rd_a);
    exp_t e;
    @(posedge clk);
    #1;
    rw_read  = rw_rd;
    rw_write = rw_wr;
    rw_addr  = rw_a;
    rw_din   = rw_d;
    read     = rd_rd;
    rd_addr  = rd_a;
    if (ready) begin
      if (rd_rd) begin
        e.data = model[rd_a];
        e.padr = expect_padr(rd_a);
        e.due  = cycle + LATENCY;
        rd_q.push_back(e);
      end
      if (rw_rd && !rw_wr) begin
        e.data = model[rw_a];
        e.padr = expect_padr(rw_a);
        e.due  = cycle + LATENCY;
        rw_q.push_back(e);
      end
      if (rw_wr) begin
        model[rw_a] = rw_d;
      end
    end
  endtask

  task automatic drain_reads();
    repeat (LATENCY + 2) drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0);
    if (rw_q.size() != 0 || rd_q.size() != 0) begin
      stop_with_failure("Reads still outstanding after the return latency");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_init_clear();
    int waited;
    waited = 0;
    if (ready !== 1'b0) begin
      stop_with_failure("ready is not low right after reset");
    end
    while (!ready_seen) begin
      @(posedge clk);
      #1;
      if (ready === 1'b1) begin
        rw_read    = 1'b0;
        rw_write   = 1'b0;
        read       = 1'b0;
        ready_seen = 1'b1;
      end else begin
        waited++;
        if (waited > `MPMEM_NUMVROW + 1) begin
          stop_with_failure("ready did not rise after the clear sweep");
        end
        rw_read  = take_bits(1);   // Ignored while not ready.
        rw_write = take_bits(1);
        rw_addr  = take_bits(`MPMEM_BITADDR);
        rw_din   = take_bits(`MPMEM_WIDTH);
        read     = take_bits(1);
        rd_addr  = take_bits(`MPMEM_BITADDR);
      end
    end
    for (int a = 0; a < `MPMEM_NUMADDR; a++) begin
      drive_cycle(1'b1, 1'b0, a, '0, 1'b1, `MPMEM_NUMADDR - 1 - a);
    end
    drain_reads();
  endtask

  task automatic test_write_read();
    for (int a = 0; a < `MPMEM_NUMADDR; a++) begin
      drive_cycle(1'b0, 1'b1, a, take_bits(`MPMEM_WIDTH), 1'b0, '0);
    end
    for (int a = 0; a < `MPMEM_NUMADDR; a++) begin
      drive_cycle(1'b1, 1'b0, a, '0, 1'b1, (a * 37 + 11) % `MPMEM_NUMADDR);
    end
    drain_reads();
  endtask

  task automatic test_stream();
    mpmem_data_pkg::addr_t rw_a;
    mpmem_data_pkg::addr_t rd_a;
    for (int i = 0; i < N_STREAM; i++) begin
      rw_a = take_bits(`MPMEM_BITADDR);
      rd_a = take_bits(`MPMEM_BITADDR);
      if (take_bits(1)) begin
        rd_a = rd_a - rd_a % `MPMEM_NUMVBNK + rw_a % `MPMEM_NUMVBNK;  // Same bank.
      end
      drive_cycle(1'b1, 1'b0, rw_a, '0, 1'b1, rd_a);
    end
    drain_reads();
  endtask

  task automatic test_collision();
    mpmem_data_pkg::addr_t a;
    for (int i = 0; i < N_COLLIDE; i++) begin
      a = take_bits(`MPMEM_BITADDR);
      drive_cycle(1'b0, 1'b1, a, take_bits(`MPMEM_WIDTH), 1'b1, a);  // Old word expected.
      drive_cycle(1'b1, 1'b0, a, '0, 1'b1, a);
    end
    drain_reads();
  endtask

  task automatic test_read_write_same();
    mpmem_data_pkg::addr_t a;
    for (int i = 0; i < N_BOTH; i++) begin
      a = take_bits(`MPMEM_BITADDR);
      drive_cycle(1'b1, 1'b1, a, take_bits(`MPMEM_WIDTH), 1'b0, '0);  // No rw_vld.
      drive_cycle(1'b1, 1'b0, a, '0, 1'b1, a);
    end
    drain_reads();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst      = 1'b1;
    rw_read  = 1'b0;
    rw_write = 1'b0;
    rw_addr  = '0;
    rw_din   = '0;
    read     = 1'b0;
    rd_addr  = '0;
    for (int a = 0; a < `MPMEM_NUMADDR; a++) begin
      model[a] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    test_init_clear();
    test_write_read();
    test_stream();
    test_collision();
    test_read_write_same();
    if (rw_q.size() != 0 || rd_q.size() != 0) begin
      stop_with_failure("Reads left outstanding at the end of the run");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

/* mpmem.f */
+incdir+.
mpmem_data_pkg.sv
mpmem_ctrl_pkg.sv
mpmem_ctrl.sv
mpmem_bank_1rw.sv
mpmem_bank_1r1w.sv
mpmem_rd_mux.sv
mpmem_top.sv
mpmem_tb.sv

/* Bender.yml */
package:
  name: mpmem

sources:
  - include_dirs:
      - .
    files:
      - mpmem_data_pkg.sv
      - mpmem_ctrl_pkg.sv
      - mpmem_ctrl.sv
      - mpmem_bank_1rw.sv
      - mpmem_bank_1r1w.sv
      - mpmem_rd_mux.sv
      - mpmem_top.sv
      - target: test
        files:
          - mpmem_tb.sv
